// File: sources.f
+incdir+.
laser_pkg.sv
cover_if.sv
point_buffer.sv
cover_counter.sv
circle_search.sv
laser_top.sv
tb_laser.sv

// File: Makefile
TOOL       = verilator
TOP        = tb_laser
RTL_TOP    = laser_top
FILELIST   = sources.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing
BUILD      = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Run passed, see $(LOG)"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: laser_model.svh
`ifndef LASER_MODEL_SVH
`define LASER_MODEL_SVH

typedef int pt_list_t [NUM_POINTS];

function automatic bit in_circle(input int px, input int py, input int cx, input int cy);
    int dx;
    int dy;
    dx = px - cx;
    dy = py - cy;
    return (dx * dx + dy * dy) <= laser_pkg::RADIUS_SQ; // Boundary is inside
endfunction

function automatic int union_count(input pt_list_t xs, input pt_list_t ys, input int ax,
                                   input int ay, input int bx, input int by, input bit use_b);
    int i;
    int n;
    n = 0;
    for (i = 0; i < NUM_POINTS; i++) begin
        if (in_circle(xs[i], ys[i], ax, ay) || (use_b && in_circle(xs[i], ys[i], bx, by))) begin
            n++;
        end
    end
    return n;
endfunction

// One sweep of one circle, whole grid or clipped window around its centre
function automatic void sweep(input pt_list_t xs, input pt_list_t ys, input int ctr_x,
                              input int ctr_y, input bit whole, input int ox, input int oy,
                              input bit use_o, output int best_x, output int best_y,
                              output int best_n);
    int lo_x;
    int hi_x;
    int lo_y;
    int hi_y;
    int x;
    int y;
    int n;
    lo_x = whole ? 0 : ((ctr_x < laser_pkg::WINDOW) ? 0 : ctr_x - laser_pkg::WINDOW);
    lo_y = whole ? 0 : ((ctr_y < laser_pkg::WINDOW) ? 0 : ctr_y - laser_pkg::WINDOW);
    hi_x = whole ? laser_pkg::GRID_MAX : ctr_x + laser_pkg::WINDOW;
    hi_y = whole ? laser_pkg::GRID_MAX : ctr_y + laser_pkg::WINDOW;
    if (hi_x > laser_pkg::GRID_MAX) hi_x = laser_pkg::GRID_MAX;
    if (hi_y > laser_pkg::GRID_MAX) hi_y = laser_pkg::GRID_MAX;
    best_x = ctr_x;
    best_y = ctr_y;
    best_n = 0;
    for (y = lo_y; y <= hi_y; y++) begin
        for (x = lo_x; x <= hi_x; x++) begin
            n = union_count(xs, ys, x, y, ox, oy, use_o);
            if (n >= best_n) begin // Later candidate takes a tie
                best_x = x;
                best_y = y;
                best_n = n;
            end
        end
    end
endfunction

function automatic void search_model(input pt_list_t xs, input pt_list_t ys, output int c1x,
                                     output int c1y, output int c2x, output int c2y,
                                     output int cnt);
    int r;
    int n;
    c1x = 0;
    c1y = 0;
    c2x = 0;
    c2y = 0;
    cnt = 0;
    for (r = 0; r < NUM_ROUNDS; r++) begin
        sweep(xs, ys, c1x, c1y, r == 0, c2x, c2y, r != 0, c1x, c1y, n);
        sweep(xs, ys, c2x, c2y, r == 0, c1x, c1y, 1'b1, c2x, c2y, cnt);
    end
endfunction

`endif

// File: tb_laser.sv
`timescale 1ns/1ps

module tb_laser;

    localparam int NUM_POINTS  = 40;
    localparam int NUM_ROUNDS  = 3;
    localparam int CYCLE_LIMIT = 400000; // Nine loads of about 36k cycles each, plus margin

    logic              CLK;
    logic              RST;
    laser_pkg::coord_t pt_x;
    laser_pkg::coord_t pt_y;
    logic              req;
    logic              ack;
    laser_pkg::coord_t c1_x;
    laser_pkg::coord_t c1_y;
    laser_pkg::coord_t c2_x;
    laser_pkg::coord_t c2_y;
    laser_pkg::count_t cover_count;
    logic              done;

    `include "laser_model.svh"

    pt_list_t    set_x;
    pt_list_t    set_y;
    int          mismatches;
    int          failures;
    int          checks;
    int          cycles;
    bit          busy;    // Between full and done
    bit          holding; // Results must not move
    logic [21:0] held;
    logic        prev_req;
    logic        prev_ack;

    laser_top #(
        .NUM_POINTS (NUM_POINTS),
        .NUM_ROUNDS (NUM_ROUNDS)
    ) laser_top_inst (
        .CLK         (CLK),
        .RST         (RST),
        .pt_x        (pt_x),
        .pt_y        (pt_y),
        .req         (req),
        .ack         (ack),
        .c1_x        (c1_x),
        .c1_y        (c1_y),
        .c2_x        (c2_x),
        .c2_y        (c2_y),
        .cover_count (cover_count),
        .done        (done)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic note_failure(input string what);
        failures++;
        $display("Error: %s", what);
    endtask

    task automatic compare_value(input string test, input string field, input int expected,
                                 input int actual);
        checks++;
        assert (expected == actual) else begin
            mismatches++;
            $display("Mismatch %s %s: expected %0d, actual %0d", test, field, expected, actual);
        end
    endtask

    task automatic print_counts();
        $display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        note_failure("timeout, the test sets did not finish in time");
        print_counts();
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Four-phase rules, seen with the values from before each edge
    always @(posedge CLK) begin
        if (RST) begin
            prev_req = 1'b0;
            prev_ack = 1'b0;
        end else begin
            assert (!(ack && !prev_ack && !prev_req)) else note_failure("ack rose without req");
            assert (!(!ack && prev_ack && prev_req)) else note_failure("ack fell with req high");
            assert (!(ack && busy)) else note_failure("ack went high during a search");
            prev_req = req;
            prev_ack = ack;
        end
    end

    always @(negedge CLK) begin
        if (holding && !RST) begin
            assert ({c1_x, c1_y, c2_x, c2_y, cover_count} == held)
                else note_failure("results changed before the next load completed");
        end
    end

    task automatic fill_set(input int kind);
        int i;
        int sx;
        int sy;
        int bx [5];
        int by [5];
        sx = $urandom % 16;
        sy = $urandom % 16;
        for (i = 0; i < 5; i++) begin
            bx[i] = $urandom % 16;
            by[i] = $urandom % 16;
        end
        for (i = 0; i < NUM_POINTS; i++) begin
            case (kind)
                1: begin
                    set_x[i] = sx; // All in one spot
                    set_y[i] = sy;
                end
                2: begin
                    set_x[i] = (i % 2) * 15; // Grid corners only
                    set_y[i] = ((i / 2) % 2) * 15;
                end
                3: begin
                    set_x[i] = bx[i % 5];
                    set_y[i] = by[i % 5];
                end
                default: begin
                    set_x[i] = $urandom % 16;
                    set_y[i] = $urandom % 16;
                end
            endcase
        end
    endtask

    task automatic load_point(input int x, input int y);
        @(negedge CLK);
        pt_x = 4'(x);
        pt_y = 4'(y);
        req  = 1'b1;
        @(negedge CLK);
        while (!ack) @(negedge CLK);
        req = 1'b0;
        @(negedge CLK);
        while (ack) @(negedge CLK);
    endtask

    task automatic load_set();
        int i;
        for (i = 0; i < NUM_POINTS; i++) begin
            load_point(set_x[i], set_y[i]);
        end
        holding = 1'b0;
        busy    = 1'b1;
    endtask

    task automatic run_set(input string name, input bit poke_req);
        int ex1;
        int ey1;
        int ex2;
        int ey2;
        int en;
        load_set();
        if (poke_req) begin
            @(negedge CLK);
            req = 1'b1; // Buffer is locked and must ignore this
            repeat (20) @(negedge CLK);
            req = 1'b0;
        end
        @(negedge CLK);
        while (!done) @(negedge CLK);
        busy = 1'b0;
        search_model(set_x, set_y, ex1, ey1, ex2, ey2, en);
        compare_value(name, "c1_x", ex1, int'(c1_x));
        compare_value(name, "c1_y", ey1, int'(c1_y));
        compare_value(name, "c2_x", ex2, int'(c2_x));
        compare_value(name, "c2_y", ey2, int'(c2_y));
        compare_value(name, "cover_count", en, int'(cover_count));
        compare_value(name, "recount", union_count(set_x, set_y, int'(c1_x), int'(c1_y),
                      int'(c2_x), int'(c2_y), 1'b1), int'(cover_count));
        held    = {c1_x, c1_y, c2_x, c2_y, cover_count};
        holding = 1'b1;
    endtask

    task automatic abort_with_reset();
        fill_set(0);
        load_set();
        repeat (2000) @(negedge CLK);
        assert (!done) else note_failure("done pulsed early in the aborted search");
        holding = 1'b0;
        RST     = 1'b1;
        repeat (3) @(negedge CLK);
        busy = 1'b0;
        RST  = 1'b0;
        @(negedge CLK);
        assert (!done && !ack && {c1_x, c1_y, c2_x, c2_y, cover_count} == '0)
            else note_failure("reset during a search did not clear done and the results");
    endtask

    initial begin
        RST        = 1'b1;
        req        = 1'b0;
        pt_x       = '0;
        pt_y       = '0;
        mismatches = 0;
        failures   = 0;
        checks     = 0;
        busy       = 1'b0;
        holding    = 1'b0;
        held       = '0;
        prev_req   = 1'b0;
        prev_ack   = 1'b0;
        void'($urandom(52828));
        repeat (5) @(negedge CLK);
        RST = 1'b0;
        @(negedge CLK);
        assert (!ack && !done) else note_failure("ack or done high after reset");
        fill_set(0);
        run_set("random_a", 1'b0);
        fill_set(0);
        run_set("random_b", 1'b0);
        fill_set(1);
        run_set("one_spot", 1'b0);
        fill_set(2);
        run_set("corners", 1'b0);
        fill_set(3);
        run_set("duplicates", 1'b0);
        abort_with_reset();
        fill_set(0);
        run_set("after_reset", 1'b0);
        fill_set(0);
        run_set("req_in_search", 1'b1);
        fill_set(0);
        run_set("random_c", 1'b0);
        print_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: laser_top.sv
`timescale 1ns/1ps

module laser_top #(
    parameter int NUM_POINTS = 40,
    parameter int NUM_ROUNDS = 3
) (
    input  logic              CLK,
    input  logic              RST,
    input  laser_pkg::coord_t pt_x,
    input  laser_pkg::coord_t pt_y,
    input  logic              req,
    output logic              ack,
    output laser_pkg::coord_t c1_x,
    output laser_pkg::coord_t c1_y,
    output laser_pkg::coord_t c2_x,
    output laser_pkg::coord_t c2_y,
    output laser_pkg::count_t cover_count,
    output logic              done
);

    logic              full;
    logic [5:0]        rd_idx;
    laser_pkg::point_t rd_pt;

    cover_if cov_bus ();

    point_buffer #(
        .NUM_POINTS (NUM_POINTS)
    ) point_buffer_inst (
        .CLK         (CLK),
        .RST         (RST),
        .pt_x        (pt_x),
        .pt_y        (pt_y),
        .req         (req),
        .ack         (ack),
        .full        (full),
        .search_done (done), // Reopens loading for the next set
        .rd_idx      (rd_idx),
        .rd_pt       (rd_pt)
    );

    cover_counter #(
        .NUM_POINTS (NUM_POINTS)
    ) cover_counter_inst (
        .CLK    (CLK),
        .RST    (RST),
        .cov    (cov_bus.counter),
        .rd_idx (rd_idx),
        .rd_pt  (rd_pt)
    );

    circle_search #(
        .NUM_POINTS (NUM_POINTS),
        .NUM_ROUNDS (NUM_ROUNDS)
    ) circle_search_inst (
        .CLK         (CLK),
        .RST         (RST),
        .full        (full),
        .srch        (cov_bus.search),
        .c1_x        (c1_x),
        .c1_y        (c1_y),
        .c2_x        (c2_x),
        .c2_y        (c2_y),
        .cover_count (cover_count),
        .done        (done)
    );

endmodule

// File: circle_search.sv
`timescale 1ns/1ps

module circle_search #(
    parameter int NUM_POINTS = 40,
    parameter int NUM_ROUNDS = 3
) (
    input  logic              CLK,
    input  logic              RST,
    input  logic              full,
    cover_if.search           srch,
    output laser_pkg::coord_t c1_x,
    output laser_pkg::coord_t c1_y,
    output laser_pkg::coord_t c2_x,
    output laser_pkg::coord_t c2_y,
    output laser_pkg::count_t cover_count,
    output logic              done
);

    localparam int RW = (NUM_ROUNDS > 1) ? $clog2(NUM_ROUNDS) : 1;
    localparam logic [RW-1:0]     LAST_ROUND = RW'(NUM_ROUNDS - 1);
    localparam laser_pkg::count_t MAX_COUNT  = laser_pkg::count_t'(NUM_POINTS);
    localparam laser_pkg::coord_t GRID_HI    = laser_pkg::coord_t'(laser_pkg::GRID_MAX);
    localparam laser_pkg::coord_t WIN        = laser_pkg::coord_t'(laser_pkg::WINDOW);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_WAIT
    } state_t;

    state_t            state;
    logic [RW-1:0]     round;
    logic              circ;   // Low while circle 1 is swept
    laser_pkg::coord_t cx;
    laser_pkg::coord_t cy;
    laser_pkg::coord_t lo_x;
    laser_pkg::coord_t hi_x;
    laser_pkg::coord_t hi_y;
    laser_pkg::point_t c1;
    laser_pkg::point_t c2;
    laser_pkg::count_t best;

    laser_pkg::point_t cand;
    logic              win;
    logic              last_x;
    logic              last_y;
    logic              next_full;
    laser_pkg::point_t next_ctr;
    laser_pkg::coord_t nlo_x;
    laser_pkg::coord_t nhi_x;
    laser_pkg::coord_t nlo_y;
    laser_pkg::coord_t nhi_y;
    laser_pkg::point_t c2_final;
    laser_pkg::count_t best_final;

    function automatic laser_pkg::coord_t win_lo(input laser_pkg::coord_t c);
        return (c < WIN) ? laser_pkg::coord_t'(0) : c - WIN;
    endfunction

    function automatic laser_pkg::coord_t win_hi(input laser_pkg::coord_t c);
        return (c > GRID_HI - WIN) ? GRID_HI : c + WIN;
    endfunction

    assign cand   = '{x: cx, y: cy};
    assign win    = (srch.count >= best); // Later candidate wins a tie
    assign last_x = (cx == hi_x);
    assign last_y = (cy == hi_y);

    // Window of the sweep that follows the current one
    assign next_full = (state == ST_IDLE) || (!circ && round == '0);
    assign next_ctr  = circ ? c1 : c2;
    assign nlo_x     = next_full ? laser_pkg::coord_t'(0) : win_lo(next_ctr.x);
    assign nhi_x     = next_full ? GRID_HI : win_hi(next_ctr.x);
    assign nlo_y     = next_full ? laser_pkg::coord_t'(0) : win_lo(next_ctr.y);
    assign nhi_y     = next_full ? GRID_HI : win_hi(next_ctr.y);

    assign c2_final   = win ? cand : c2;
    assign best_final = win ? srch.count : best;

    assign srch.start     = (state == ST_START);
    assign srch.cand      = cand;
    assign srch.other     = circ ? c1 : c2;
    assign srch.use_other = circ || (round != '0);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state       <= ST_IDLE;
            round       <= '0;
            circ        <= 1'b0;
            cx          <= '0;
            cy          <= '0;
            lo_x        <= '0;
            hi_x        <= '0;
            hi_y        <= '0;
            c1          <= '0;
            c2          <= '0;
            best        <= '0;
            c1_x        <= '0;
            c1_y        <= '0;
            c2_x        <= '0;
            c2_y        <= '0;
            cover_count <= '0;
            done        <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (full) begin
                        round <= '0;
                        circ  <= 1'b0;
                        c1    <= '0;
                        c2    <= '0;
                        best  <= '0;
                        lo_x  <= nlo_x;
                        hi_x  <= nhi_x;
                        hi_y  <= nhi_y;
                        cx    <= nlo_x;
                        cy    <= nlo_y;
                        state <= ST_START;
                    end
                end
                ST_START: state <= ST_WAIT;
                ST_WAIT: begin
                    if (srch.valid) begin
                        if (win) begin
                            best <= srch.count;
                            if (circ) begin
                                c2 <= cand;
                            end else begin
                                c1 <= cand;
                            end
                        end
                        state <= ST_START;
                        if (!last_x) begin
                            cx <= cx + 4'd1; // Raster order, x fastest
                        end else if (!last_y) begin
                            cx <= lo_x;
                            cy <= cy + 4'd1;
                        end else if (circ && round == LAST_ROUND) begin
                            c1_x        <= c1.x;
                            c1_y        <= c1.y;
                            c2_x        <= c2_final.x;
                            c2_y        <= c2_final.y;
                            cover_count <= (best_final > MAX_COUNT) ? MAX_COUNT : best_final;
                            done        <= 1'b1;
                            state       <= ST_IDLE;
                        end else begin
                            circ <= ~circ;
                            if (circ) begin
                                round <= round + 1'b1;
                            end
                            best <= '0;
                            lo_x <= nlo_x;
                            hi_x <= nhi_x;
                            hi_y <= nhi_y;
                            cx   <= nlo_x;
                            cy   <= nlo_y;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: cover_counter.sv
`timescale 1ns/1ps

module cover_counter #(
    parameter int NUM_POINTS = 40
) (
    input  logic              CLK,
    input  logic              RST,
    cover_if.counter          cov,
    output logic [5:0]        rd_idx,
    input  laser_pkg::point_t rd_pt
);

    localparam logic [5:0] LAST_IDX = 6'(NUM_POINTS - 1);

    logic [5:0]        idx;
    logic              reading;
    logic              rd_vld;
    logic              d_vld;
    logic              valid_q;
    laser_pkg::count_t acc;

    laser_pkg::point_t cand_q;
    laser_pkg::point_t other_q;
    logic              use_other_q;

    laser_pkg::coord_t dxc;
    laser_pkg::coord_t dyc;
    laser_pkg::coord_t dxo;
    laser_pkg::coord_t dyo;

    logic [8:0]        dist_c;
    logic [8:0]        dist_o;
    logic              hit;

    function automatic laser_pkg::coord_t abs_diff(input laser_pkg::coord_t a,
                                                   input laser_pkg::coord_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    // Address 0 sits on the bus while idle, so the first read overlaps start
    assign rd_idx = idx;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            idx         <= '0;
            reading     <= 1'b0;
            rd_vld      <= 1'b0;
            d_vld       <= 1'b0;
            valid_q     <= 1'b0;
            acc         <= '0;
            use_other_q <= 1'b0;
        end else begin
            if (cov.start) begin
                idx         <= (NUM_POINTS > 1) ? 6'd1 : 6'd0;
                reading     <= (NUM_POINTS > 1);
                use_other_q <= cov.use_other;
            end else if (reading) begin
                if (idx == LAST_IDX) begin
                    idx     <= '0;
                    reading <= 1'b0;
                end else begin
                    idx <= idx + 6'd1;
                end
            end

            rd_vld  <= cov.start | reading;
            d_vld   <= rd_vld;
            valid_q <= d_vld & ~rd_vld; // Last point leaves stage 2

            if (cov.start) begin
                acc <= '0;
            end else if (d_vld && hit) begin
                acc <= acc + 6'd1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cov.start) begin
            cand_q  <= cov.cand;
            other_q <= cov.other;
        end
        dxc <= abs_diff(rd_pt.x, cand_q.x); // Stage 1
        dyc <= abs_diff(rd_pt.y, cand_q.y);
        dxo <= abs_diff(rd_pt.x, other_q.x);
        dyo <= abs_diff(rd_pt.y, other_q.y);
    end

    // Stage 2, squared distances feed the accumulator directly
    assign dist_c = 9'(dxc) * 9'(dxc) + 9'(dyc) * 9'(dyc);
    assign dist_o = 9'(dxo) * 9'(dxo) + 9'(dyo) * 9'(dyo);
    assign hit    = (dist_c <= 9'(laser_pkg::RADIUS_SQ))
                  | (use_other_q & (dist_o <= 9'(laser_pkg::RADIUS_SQ)));

    assign cov.count = acc;
    assign cov.valid = valid_q;

endmodule

// File: point_buffer.sv
`timescale 1ns/1ps

module point_buffer #(
    parameter int NUM_POINTS = 40
) (
    input  logic              CLK,
    input  logic              RST,
    input  laser_pkg::coord_t pt_x,
    input  laser_pkg::coord_t pt_y,
    input  logic              req,
    output logic              ack,
    output logic              full,
    input  logic              search_done,
    input  logic [5:0]        rd_idx,
    output laser_pkg::point_t rd_pt
);

    localparam logic [5:0] LAST_IDX = 6'(NUM_POINTS - 1);

    typedef enum logic [1:0] {
        LD_WAIT_REQ,
        LD_WAIT_DROP,
        LD_LOCKED
    } ld_state_t;

    ld_state_t         state;
    logic [5:0]        wr_idx;
    laser_pkg::point_t mem [NUM_POINTS];

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state  <= LD_WAIT_REQ;
            wr_idx <= '0;
            ack    <= 1'b0;
            full   <= 1'b0;
        end else begin
            full <= 1'b0;
            case (state)
                LD_WAIT_REQ: begin
                    if (req) begin
                        ack   <= 1'b1; // Point is written on this edge
                        state <= LD_WAIT_DROP;
                    end
                end
                LD_WAIT_DROP: begin
                    if (!req) begin
                        ack <= 1'b0;
                        if (wr_idx == LAST_IDX) begin
                            full  <= 1'b1;
                            state <= LD_LOCKED;
                        end else begin
                            wr_idx <= wr_idx + 6'd1;
                            state  <= LD_WAIT_REQ;
                        end
                    end
                end
                LD_LOCKED: begin
                    // Search owns the store until it reports done
                    if (search_done) begin
                        wr_idx <= '0;
                        state  <= LD_WAIT_REQ;
                    end
                end
                default: state <= LD_WAIT_REQ;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == LD_WAIT_REQ && req) begin
            mem[wr_idx] <= '{x: pt_x, y: pt_y};
        end
        rd_pt <= mem[rd_idx]; // One cycle read latency
    end

endmodule

// File: cover_if.sv
`timescale 1ns/1ps

interface cover_if;

    logic               start;
    laser_pkg::point_t  cand;
    laser_pkg::point_t  other;
    logic               use_other;
    laser_pkg::count_t  count;
    logic               valid;

    modport counter (
        input  start,
        input  cand,
        input  other,
        input  use_other,
        output count,
        output valid
    );

    modport search (
        output start,
        output cand,
        output other,
        output use_other,
        input  count,
        input  valid
    );

endinterface

// File: laser_pkg.sv
package laser_pkg;

    // Grid coordinate, 0 to 15
    typedef logic [3:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Covered point count
    typedef logic [5:0] count_t;

    localparam int RADIUS_SQ = 16; // Boundary counts as inside
    localparam int WINDOW    = 4;  // Half width of the refinement window
    localparam int GRID_MAX  = 15;

endpackage
